/* dv/iic_master_tb.sv */
module iic_master_tb
        import iic_pkg::*;
();

        localparam int SYS_HZ  = 4_000_000;
        localparam int BUS_HZ  = 500_000;
        localparam int QTR_CYC = SYS_HZ / BUS_HZ / 4;

        logic                   sysclk = 1'b0;
        logic                   sysrst_n;
        logic                   iic_start;
        logic   [CMD_W-1:0]     cmd;
        logic   [BYTE_W-1:0]    tx_data;
        wire                    iic_sda;
        logic                   iic_scl;
        logic                   iic_ready;
        logic                   iic_done;
        logic                   ack;
        logic   [BYTE_W-1:0]    rx_data;

        logic                   slv_clear;
        logic                   slv_rd_mode;
        logic                   slv_sta;
        logic                   slv_ack_bit;
        logic   [BYTE_W-1:0]    slv_rd_byte;
        int                     slv_start_cnt;
        int                     slv_stop_cnt;
        int                     slv_byte_cnt;
        logic   [BYTE_W-1:0]    slv_wr_byte;
        logic                   slv_master_ack;

        logic   [7:0]           pat_cmd[$];
        logic   [7:0]           pat_tx[$];
        logic   [7:0]           pat_ack[$];
        logic   [7:0]           pat_rd[$];
        logic   [7:0]           pat_starts[$];
        logic   [7:0]           pat_stops[$];

        int                     done_cnt = 0;
        int                     cycle_cnt = 0;
        int                     cycle_limit = 0;

        iic_master_top #(
                .SYS_CLOCK_HZ   (SYS_HZ),
                .SCL_HZ         (BUS_HZ)
        ) u_dut (
                .i_sysclk       (sysclk),
                .i_sysrst_n     (sysrst_n),
                .i_iic_start    (iic_start),
                .i_cmd          (cmd),
                .i_tx_data      (tx_data),
                .iic_sda        (iic_sda),
                .o_iic_scl      (iic_scl),
                .o_iic_ready    (iic_ready),
                .o_iic_done     (iic_done),
                .o_ack          (ack),
                .o_rx_data      (rx_data)
        );

        pullup (iic_sda);

        iic_slave_model u_slave (
                .i_sysclk       (sysclk),
                .i_clear        (slv_clear),
                .i_rd_mode      (slv_rd_mode),
                .i_sta          (slv_sta),
                .i_ack_bit      (slv_ack_bit),
                .i_rd_byte      (slv_rd_byte),
                .i_scl          (iic_scl),
                .io_sda         (iic_sda),
                .o_start_cnt    (slv_start_cnt),
                .o_stop_cnt     (slv_stop_cnt),
                .o_byte_cnt     (slv_byte_cnt),
                .o_wr_byte      (slv_wr_byte),
                .o_master_ack   (slv_master_ack)
        );

        initial
        begin
                forever
                begin
                        #2 sysclk = ~sysclk;
                end
        end

        always @(negedge sysclk)
        begin
                if (iic_done)
                        done_cnt <= done_cnt + 1;
        end

        always @(posedge sysclk)
        begin
                cycle_cnt <= cycle_cnt + 1;
                if (cycle_limit > 0 && cycle_cnt >= cycle_limit)
                begin
                        $display("timeout after %0d cycles, a transfer never completed", cycle_cnt);
                        $display("sim failed");
                        $fatal(1, "run stopped by the cycle limit");
                end
        end

        task automatic expect_eq(input string name, input logic [31:0] actual,
                                 input logic [31:0] expected);
                if (actual !== expected)
                begin
                        $display("Fail at %0t: %s is %0h, expected %0h", $time, name, actual,
                                 expected);
                        $display("sim failed");
                        $fatal(1, "value mismatch");
                end
        endtask

        task automatic load_patterns();
                int             fd;
                int             n;
                string          line;
                logic   [7:0]   c, t, a, r, s, p;
                fd = $fopen("dv/iic_patterns.txt", "r");
                if (fd == 0)
                begin
                        $display("could not open the pattern file dv/iic_patterns.txt");
                        $display("sim failed");
                        $fatal(1, "no stimulus");
                end
                while (!$feof(fd))
                begin
                        line = "";
                        if ($fgets(line, fd) == 0 || line.len() == 0 || line[0] == "#")
                                continue;
                        n = $sscanf(line, "%h %h %h %h %h %h", c, t, a, r, s, p);
                        if (n == 6)
                        begin
                                pat_cmd.push_back(c);
                                pat_tx.push_back(t);
                                pat_ack.push_back(a);
                                pat_rd.push_back(r);
                                pat_starts.push_back(s);
                                pat_stops.push_back(p);
                        end
                end
                $fclose(fd);
                if (pat_cmd.size() == 0)
                begin
                        $display("the pattern file holds no commands");
                        $display("sim failed");
                        $fatal(1, "no stimulus");
                end
        endtask

        task automatic run_pattern(input int idx);
                logic   [7:0]   c;
                int             quarters;
                int             cycles;
                int             bytes_before;
                int             dones_before;
                c = pat_cmd[idx];
                while (iic_ready !== 1'b1)
                        @(negedge sysclk);
                slv_rd_mode = c[CMD_RD];
                slv_sta     = c[CMD_STA];
                slv_ack_bit = pat_ack[idx][0];
                slv_rd_byte = pat_rd[idx];
                slv_clear   = 1'b1;
                repeat (2) @(negedge sysclk);
                slv_clear    = 1'b0;
                bytes_before = slv_byte_cnt;
                dones_before = done_cnt;
                iic_start    = 1'b1;
                cmd          = c[CMD_W-1:0];
                tx_data      = pat_tx[idx];
                @(negedge sysclk);
                cycles = 1;
                expect_eq("o_iic_ready", iic_ready, 1'b0);
                tx_data = ~pat_tx[idx];         // byte must already be captured
                // start stays high while busy and must be ignored
                repeat (8) @(negedge sysclk);
                cycles    = cycles + 8;
                iic_start = 1'b0;
                while (iic_done !== 1'b1)
                begin
                        @(negedge sysclk);
                        cycles = cycles + 1;
                end
                quarters = 4 * c[CMD_STA] + 8 * 4 + 4 + 4 * c[CMD_STO];
                expect_eq("transfer cycles", cycles, QTR_CYC * quarters + 1);
                @(negedge sysclk);
                expect_eq("o_iic_done", iic_done, 1'b0);
                expect_eq("o_iic_ready", iic_ready, 1'b1);
                expect_eq("done pulses", done_cnt, dones_before + 1);
                expect_eq("slave byte count", slv_byte_cnt, bytes_before + 1);
                expect_eq("start conditions", slv_start_cnt, pat_starts[idx]);
                expect_eq("stop conditions", slv_stop_cnt, pat_stops[idx]);
                if (c[CMD_WR])
                begin
                        expect_eq("slave write byte", slv_wr_byte, pat_tx[idx]);
                        expect_eq("o_ack", ack, pat_ack[idx][0]);
                end
                else
                begin
                        expect_eq("o_rx_data", rx_data, pat_rd[idx]);
                        expect_eq("master ack bit", slv_master_ack, c[CMD_ACK] ? 1'b0 : 1'b1);
                end
        endtask

        initial
        begin
                sysrst_n    = 1'b0;
                iic_start   = 1'b0;
                cmd         = '0;
                tx_data     = '0;
                slv_clear   = 1'b0;
                slv_rd_mode = 1'b0;
                slv_sta     = 1'b0;
                slv_ack_bit = 1'b1;
                slv_rd_byte = '0;
                load_patterns();
                cycle_limit = 120 * pat_cmd.size() + 100;
                repeat (10) @(negedge sysclk);
                sysrst_n = 1'b1;
                @(negedge sysclk);
                expect_eq("o_iic_ready", iic_ready, 1'b1);
                expect_eq("o_iic_done", iic_done, 1'b0);
                expect_eq("o_iic_scl", iic_scl, 1'b1);
                expect_eq("iic_sda", iic_sda, 1'b1);
                for (int i = 0; i < pat_cmd.size(); i++)
                        run_pattern(i);
                repeat (20) @(negedge sysclk);
                expect_eq("total done pulses", done_cnt, pat_cmd.size());
                expect_eq("total slave bytes", slv_byte_cnt, pat_cmd.size());
                $display("sim passed");
                $finish;
        end

endmodule

/* dv/iic_patterns.txt */
# cmd tx_data slave_ack slave_rd_byte starts stops, all hex
# cmd flags: wr=01 sta=02 rd=04 sto=08 ack=10 nack=20
0b a5 0 00 1 1
0b 3c 1 00 1 1
03 81 0 00 1 0
01 ff 1 00 0 0
09 00 0 00 0 1
16 00 0 5a 1 0
24 00 0 c3 0 0
2c 00 0 0f 0 1
1e 00 0 96 1 1
3e 00 0 e7 1 1
04 00 0 01 0 0
2e 00 0 80 1 1
14 00 0 ff 0 0
0b 00 0 00 1 1
09 6e 1 00 0 1
16 00 0 00 1 0

/* dv/iic_slave_model.sv */
module iic_slave_model
        import iic_pkg::*;
(
        input   logic                   i_sysclk,
        input   logic                   i_clear,
        input   logic                   i_rd_mode,
        input   logic                   i_sta,
        input   logic                   i_ack_bit,
        input   logic   [BYTE_W-1:0]    i_rd_byte,
        input   logic                   i_scl,
        inout   wire                    io_sda,
        output  int                     o_start_cnt,
        output  int                     o_stop_cnt,
        output  int                     o_byte_cnt,
        output  logic   [BYTE_W-1:0]    o_wr_byte,
        output  logic                   o_master_ack
);

        logic                   scl_q = 1'b1;
        logic                   sda_q = 1'b1;
        logic                   sda_in;
        logic                   armed = 1'b0;   // bits of this byte are being counted
        logic                   sda_low = 1'b0;
        logic   [BYTE_W-1:0]    sh = '0;
        int                     bit_idx = 9;

        assign io_sda = sda_low ? 1'b0 : 1'bz;

        initial
        begin
                o_start_cnt  = 0;
                o_stop_cnt   = 0;
                o_byte_cnt   = 0;
                o_wr_byte    = '0;
                o_master_ack = 1'b0;
        end

        // bus moves on the rising clock and is read on the falling one
        always @(negedge i_sysclk)
        begin
                sda_in = (io_sda !== 1'b0);     // pull-up reads as 1
                if (i_clear)
                begin
                        o_start_cnt  = 0;
                        o_stop_cnt   = 0;
                        o_wr_byte    = 'x;      // nothing recorded yet for this command
                        o_master_ack = 1'bx;
                        bit_idx      = 0;
                        armed        = !i_sta;  // wait for the start condition
                end
                else
                begin
                        if (scl_q && i_scl && sda_q && !sda_in)
                        begin
                                o_start_cnt = o_start_cnt + 1;
                                bit_idx     = 0;
                                armed       = 1'b1;
                        end
                        if (scl_q && i_scl && !sda_q && sda_in)
                                o_stop_cnt = o_stop_cnt + 1;
                        if (armed && !scl_q && i_scl && bit_idx < 9)
                        begin
                                if (bit_idx < 8)
                                        sh = {sh[BYTE_W-2:0], sda_in};
                                if (bit_idx == 7)
                                begin
                                        o_byte_cnt = o_byte_cnt + 1;
                                        if (!i_rd_mode)
                                                o_wr_byte = sh;
                                end
                                if (bit_idx == 8 && i_rd_mode)
                                        o_master_ack = sda_in;  // ninth bit comes from the master
                                bit_idx = bit_idx + 1;
                        end
                end
                // sda only moves under a low scl
                if (!i_scl)
                begin
                        if (!armed || bit_idx > 8)
                                sda_low <= 1'b0;
                        else if (i_rd_mode)
                                sda_low <= (bit_idx < 8) && !i_rd_byte[BYTE_W-1-bit_idx];
                        else
                                sda_low <= (bit_idx == 8) && !i_ack_bit;
                end
                scl_q = i_scl;
                sda_q = sda_in;
        end

endmodule

/* hw/iic_line_drv.sv */
module iic_line_drv
        import iic_pkg::*;
(
        input   logic                   i_sysclk,
        input   logic                   i_sysrst_n,
        input   iic_seg_e               i_seg,
        input   logic   [QTR_W-1:0]     i_qtr,
        input   logic                   i_step,
        input   logic                   i_tx_bit,
        input   logic                   i_master_nack,
        inout   wire                    io_iic_sda,
        output  logic                   o_iic_scl,
        output  logic                   o_ack,
        output  logic   [BYTE_W-1:0]    o_rx_data
);

        logic   scl;
        logic   sda_pull;       // high pulls sda low
        logic   data_pull;

        // sda level for quarter 0 of a data or ack bit
        always_comb
        begin
                case (i_seg)
                        SEG_WRITE:      data_pull = !i_tx_bit;
                        SEG_MASTER_ACK: data_pull = !i_master_nack;
                        default:        data_pull = 1'b0;       // slave owns sda
                endcase
        end

        always_ff @(posedge i_sysclk or negedge i_sysrst_n)
        begin
                if (!i_sysrst_n)
                begin
                        scl      <= 1'b1;
                        sda_pull <= 1'b0;
                        o_ack    <= 1'b0;
                end
                else if (i_step)
                begin
                        case (i_seg)
                                SEG_START:
                                begin
                                        case (i_qtr)
                                                2'd0:    sda_pull <= 1'b0;
                                                2'd1:    scl <= 1'b1;
                                                2'd2:    sda_pull <= 1'b1;     // sda falls under high scl
                                                default: scl <= 1'b0;
                                        endcase
                                end
                                SEG_WRITE, SEG_READ, SEG_SLAVE_ACK, SEG_MASTER_ACK:
                                begin
                                        case (i_qtr)
                                                2'd0:
                                                begin
                                                        scl      <= 1'b0;
                                                        sda_pull <= data_pull;
                                                end
                                                2'd1:
                                                        scl <= 1'b1;
                                                2'd2:
                                                begin
                                                        if (i_seg == SEG_SLAVE_ACK)
                                                                o_ack <= io_iic_sda;
                                                end
                                                default:
                                                        scl <= 1'b0;
                                        endcase
                                end
                                SEG_STOP:
                                begin
                                        case (i_qtr)
                                                2'd0:    sda_pull <= 1'b1;
                                                2'd1:    scl <= 1'b1;
                                                2'd2:    sda_pull <= 1'b0;     // sda rises under high scl
                                                default: scl <= 1'b1;
                                        endcase
                                end
                        endcase
                end
        end

        // receive byte sampled mid scl high
        always_ff @(posedge i_sysclk)
        begin
                if (i_step && i_seg == SEG_READ && i_qtr == 2'd2)
                        o_rx_data <= {o_rx_data[BYTE_W-2:0], io_iic_sda};
        end

        assign io_iic_sda = sda_pull ? 1'b0 : 1'bz;
        assign o_iic_scl  = scl;

        // only start and stop may move sda under a high scl
        a_sda_scl_high: assert property (@(posedge i_sysclk) disable iff (!i_sysrst_n)
                (scl && $past(scl) && !(i_seg inside {SEG_START, SEG_STOP}))
                |-> $stable(io_iic_sda));

endmodule

/* hw/iic_master_top.sv */
module iic_master_top
        import iic_pkg::*;
#(
        parameter int SYS_CLOCK_HZ = 50_000_000,
        parameter int SCL_HZ       = 400_000
)
(
        input   logic                   i_sysclk,
        input   logic                   i_sysrst_n,
        input   logic                   i_iic_start,
        input   logic   [CMD_W-1:0]     i_cmd,
        input   logic   [BYTE_W-1:0]    i_tx_data,
        inout   wire                    iic_sda,
        output  logic                   o_iic_scl,
        output  logic                   o_iic_ready,
        output  logic                   o_iic_done,
        output  logic                   o_ack,
        output  logic   [BYTE_W-1:0]    o_rx_data
);

        logic                   en_tick;
        logic                   qtr_tick;
        logic                   step;
        iic_seg_e               seg;
        logic   [QTR_W-1:0]     qtr;
        logic                   tx_bit;
        logic                   master_nack;

        iic_quarter_tick #(
                .SYS_CLOCK_HZ   (SYS_CLOCK_HZ),
                .SCL_HZ         (SCL_HZ)
        ) u_tick (
                .i_sysclk       (i_sysclk),
                .i_sysrst_n     (i_sysrst_n),
                .i_en           (en_tick),
                .o_tick         (qtr_tick)
        );

        iic_seq_ctrl u_seq (
                .i_sysclk       (i_sysclk),
                .i_sysrst_n     (i_sysrst_n),
                .i_iic_start    (i_iic_start),
                .i_cmd          (i_cmd),
                .i_tx_data      (i_tx_data),
                .i_tick         (qtr_tick),
                .o_iic_ready    (o_iic_ready),
                .o_iic_done     (o_iic_done),
                .o_en_tick      (en_tick),
                .o_step         (step),
                .o_seg          (seg),
                .o_qtr          (qtr),
                .o_tx_bit       (tx_bit),
                .o_master_nack  (master_nack)
        );

        iic_line_drv u_drv (
                .i_sysclk       (i_sysclk),
                .i_sysrst_n     (i_sysrst_n),
                .i_seg          (seg),
                .i_qtr          (qtr),
                .i_step         (step),
                .i_tx_bit       (tx_bit),
                .i_master_nack  (master_nack),
                .io_iic_sda     (iic_sda),
                .o_iic_scl      (o_iic_scl),
                .o_ack          (o_ack),
                .o_rx_data      (o_rx_data)
        );

endmodule

/* hw/iic_pkg.sv */
package iic_pkg;

        // command word, one flag per bit
        localparam int CMD_W = 6;

        localparam int CMD_WR   = 0;    // write one byte
        localparam int CMD_STA  = 1;    // start condition first
        localparam int CMD_RD   = 2;    // read one byte
        localparam int CMD_STO  = 3;    // stop condition last
        localparam int CMD_ACK  = 4;    // master acks the read byte
        localparam int CMD_NACK = 5;    // master nacks the read byte

        // each bus bit is split into four quarters
        localparam int QTR_W = 2;

        // bit index inside a byte
        localparam int BIT_W = 3;

        localparam int BYTE_W = 8;

        // bus segment the sequencer is walking through
        typedef enum logic [2:0] {
                SEG_IDLE,
                SEG_START,              // 4 quarters
                SEG_WRITE,              // 8 bits of 4 quarters
                SEG_READ,               // 8 bits of 4 quarters
                SEG_SLAVE_ACK,          // 4 quarters, slave drives sda
                SEG_MASTER_ACK,         // 4 quarters, master drives sda
                SEG_STOP                // 4 quarters
        } iic_seg_e;

endpackage

/* hw/iic_quarter_tick.sv */
module iic_quarter_tick
#(
        parameter int SYS_CLOCK_HZ = 50_000_000,
        parameter int SCL_HZ       = 400_000
)
(
        input   logic   i_sysclk,
        input   logic   i_sysrst_n,
        input   logic   i_en,
        output  logic   o_tick
);

        // system clocks per quarter of an scl period
        localparam int QTR_CYCLES = SYS_CLOCK_HZ / SCL_HZ / 4;
        localparam int CNT_W      = (QTR_CYCLES > 1) ? $clog2(QTR_CYCLES) : 1;
        localparam logic [CNT_W-1:0] CNT_MAX = CNT_W'(QTR_CYCLES - 1);

        logic   [CNT_W-1:0]     cnt;

        always_ff @(posedge i_sysclk or negedge i_sysrst_n)
        begin
                if (!i_sysrst_n)
                        cnt <= '0;
                else if (!i_en)
                        cnt <= '0;      // restart so the first tick is a full quarter away
                else if (cnt == CNT_MAX)
                        cnt <= '0;
                else
                        cnt <= cnt + 1'b1;
        end

        assign o_tick = i_en && (cnt == CNT_MAX);

        // scl must be slow enough for at least one clock per quarter
        a_qtr_cycles: assert property (@(posedge i_sysclk) QTR_CYCLES >= 1);

        a_no_tick_idle: assert property (@(posedge i_sysclk) disable iff (!i_sysrst_n)
                !i_en |-> !o_tick);

endmodule

/* hw/iic_seq_ctrl.sv */
module iic_seq_ctrl
        import iic_pkg::*;
(
        input   logic                   i_sysclk,
        input   logic                   i_sysrst_n,
        input   logic                   i_iic_start,
        input   logic   [CMD_W-1:0]     i_cmd,
        input   logic   [BYTE_W-1:0]    i_tx_data,
        input   logic                   i_tick,
        output  logic                   o_iic_ready,
        output  logic                   o_iic_done,
        output  logic                   o_en_tick,
        output  logic                   o_step,
        output  iic_seg_e               o_seg,
        output  logic   [QTR_W-1:0]     o_qtr,
        output  logic                   o_tx_bit,
        output  logic                   o_master_nack
);

        iic_seg_e               seg;
        logic   [QTR_W-1:0]     qtr;
        logic   [BIT_W-1:0]     bit_cnt;
        logic   [CMD_W-1:0]     cmd_q;
        logic   [BYTE_W-1:0]    tx_sh;
        logic                   done;
        logic                   accept;
        logic                   step;
        logic                   qtr_last;
        logic                   byte_last;

        assign accept    = i_iic_start && o_iic_ready;
        assign step      = i_tick && (seg != SEG_IDLE);
        assign qtr_last  = step && (&qtr);
        assign byte_last = qtr_last && (&bit_cnt);      // last quarter of bit 7

        always_ff @(posedge i_sysclk or negedge i_sysrst_n)
        begin
                if (!i_sysrst_n)
                begin
                        seg     <= SEG_IDLE;
                        qtr     <= '0;
                        bit_cnt <= '0;
                        done    <= 1'b0;
                end
                else
                begin
                        done <= 1'b0;
                        if (accept)
                        begin
                                qtr     <= '0;
                                bit_cnt <= '0;
                                if (i_cmd[CMD_STA])
                                        seg <= SEG_START;
                                else if (i_cmd[CMD_WR])
                                        seg <= SEG_WRITE;
                                else
                                        seg <= SEG_READ;
                        end
                        else if (step)
                        begin
                                qtr <= qtr + 1'b1;      // wraps to 0 at segment and bit end
                                if (qtr_last && (seg == SEG_WRITE || seg == SEG_READ))
                                        bit_cnt <= bit_cnt + 1'b1;
                                case (seg)
                                        SEG_START:
                                        begin
                                                if (qtr_last)
                                                        seg <= cmd_q[CMD_WR] ? SEG_WRITE : SEG_READ;
                                        end
                                        SEG_WRITE:
                                        begin
                                                if (byte_last)
                                                        seg <= SEG_SLAVE_ACK;
                                        end
                                        SEG_READ:
                                        begin
                                                if (byte_last)
                                                        seg <= SEG_MASTER_ACK;
                                        end
                                        SEG_SLAVE_ACK, SEG_MASTER_ACK:
                                        begin
                                                if (qtr_last && cmd_q[CMD_STO])
                                                        seg <= SEG_STOP;
                                                else if (qtr_last)
                                                begin
                                                        seg  <= SEG_IDLE;
                                                        done <= 1'b1;
                                                end
                                        end
                                        SEG_STOP:
                                        begin
                                                if (qtr_last)
                                                begin
                                                        seg  <= SEG_IDLE;
                                                        done <= 1'b1;
                                                end
                                        end
                                        default:
                                                seg <= SEG_IDLE;
                                endcase
                        end
                end
        end

        // command and byte held for the whole transfer
        always_ff @(posedge i_sysclk)
        begin
                if (accept)
                begin
                        cmd_q <= i_cmd;
                        tx_sh <= i_tx_data;
                end
                else if (qtr_last && seg == SEG_WRITE)
                        tx_sh <= {tx_sh[BYTE_W-2:0], 1'b0};     // msb first
        end

        assign o_iic_ready   = (seg == SEG_IDLE) && !done;
        assign o_iic_done    = done;
        assign o_en_tick     = (seg != SEG_IDLE);
        assign o_step        = step;
        assign o_seg         = seg;
        assign o_qtr         = qtr;
        assign o_tx_bit      = tx_sh[BYTE_W-1];
        assign o_master_nack = !cmd_q[CMD_ACK];         // ack wins over nack

        // a transfer moves exactly one byte in one direction
        a_one_dir: assert property (@(posedge i_sysclk) disable iff (!i_sysrst_n)
                accept |-> (i_cmd[CMD_WR] ^ i_cmd[CMD_RD]));

endmodule

/* sources.f */
hw/iic_pkg.sv
hw/iic_quarter_tick.sv
hw/iic_seq_ctrl.sv
hw/iic_line_drv.sv
hw/iic_master_top.sv
dv/iic_slave_model.sv
dv/iic_master_tb.sv
